/* bench/back_end_input.txt */
# in:  v f alu sdat r1 rd mr mw mt rw ww dn ht rs rt (valid flush, then execute fields)
# exp: W wr wbd O op rsd rtd ni H (wb_write wb_rd wb_data output_valid output_port
#      rs_data rt_data num_inst halted); wr wbd only checked when W=1, op when O=1
# alu results, bypass then register reads
1 0 1234 0000 0000 1 0 0 0 1 0 1 0 0 0  0 0 0000 0 0000 0000 0000 0000 0
1 0 abcd 0000 0000 2 0 0 0 1 0 1 0 1 2  0 0 0000 0 0000 0000 0000 0000 0
1 0 0042 0000 0000 3 0 0 0 1 0 1 0 1 0  1 1 1234 0 0000 1234 0000 0000 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 2  1 2 abcd 0 0000 1234 abcd 0001 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 3  1 3 0042 0 0000 abcd 0042 0002 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 3 1  0 0 0000 0 0000 0042 1234 0003 0
# store then load, two addresses
1 0 0010 beef 0000 0 0 1 0 0 0 1 0 0 3  0 0 0000 0 0000 0000 0042 0003 0
1 0 0010 0000 0000 0 1 0 1 1 0 1 0 1 2  0 0 0000 0 0000 1234 abcd 0003 0
1 0 0020 5a5a 0000 0 0 1 0 0 0 1 0 0 0  0 0 0000 0 0000 0000 0000 0003 0
1 0 0020 0000 0000 1 1 0 1 1 0 1 0 0 1  1 0 beef 0 0000 beef 1234 0004 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 3  0 0 0000 0 0000 beef 0042 0005 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 0  1 1 5a5a 0 0000 5a5a beef 0006 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 2  0 0 0000 0 0000 5a5a abcd 0007 0
# wwd without and with a register write
1 0 0000 0000 1357 0 0 0 0 0 1 1 0 2 3  0 0 0000 0 0000 abcd 0042 0007 0
1 0 0777 0000 2468 2 0 0 0 1 1 1 0 0 1  0 0 0000 0 0000 beef 5a5a 0007 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 2  0 0 0000 1 1357 abcd abcd 0007 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 3  1 2 0777 1 2468 0777 0042 0008 0
# flushed and invalid instructions, flushed store leaves memory alone
1 1 0999 0000 1111 3 0 0 0 1 1 1 0 2 3  0 0 0000 0 0000 0777 0042 0009 0
0 0 0888 0000 0000 3 0 0 0 1 1 1 0 3 0  0 0 0000 0 0000 0042 beef 0009 0
1 1 0010 dead 0000 0 0 1 0 0 0 1 0 1 2  0 0 0000 0 0000 5a5a 0777 0009 0
1 0 0010 0000 0000 3 1 0 1 1 0 1 0 3 3  0 0 0000 0 0000 0042 0042 0009 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 1  0 0 0000 0 0000 beef 5a5a 0009 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 3 2  1 3 beef 0 0000 beef 0777 0009 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 3 0  0 0 0000 0 0000 beef beef 000a 0
# only is_done instructions count
1 0 0101 0000 0000 0 0 0 0 1 0 0 0 1 2  0 0 0000 0 0000 5a5a 0777 000a 0
1 0 0202 0000 0000 1 0 0 0 1 0 1 0 3 0  0 0 0000 0 0000 beef beef 000a 0
1 0 0303 0000 0000 2 0 0 0 1 0 0 0 0 1  1 0 0101 0 0000 0101 5a5a 000a 0
1 0 0000 0000 00ff 0 0 0 0 0 1 0 0 0 1  1 1 0202 0 0000 0101 0202 000a 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 1  1 2 0303 0 0000 0303 0202 000b 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 3  0 0 0000 1 00ff 0303 beef 000b 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 1  0 0 0000 0 0000 0101 0202 000b 0
# same rd back to back, store and load at 0x00ff
1 0 1111 0000 0000 3 0 0 0 1 0 1 0 3 2  0 0 0000 0 0000 beef 0303 000b 0
1 0 2222 0000 0000 3 0 0 0 1 0 1 0 3 3  0 0 0000 0 0000 beef beef 000b 0
1 0 00ff 0f0f 0000 0 0 1 0 0 0 1 0 3 0  1 3 1111 0 0000 1111 0101 000b 0
1 0 00ff 0000 0000 0 1 0 1 1 0 1 0 3 3  1 3 2222 0 0000 2222 2222 000c 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 3 0  0 0 0000 0 0000 2222 0101 000d 0
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 3  1 0 0f0f 0 0000 0f0f 2222 000e 0
# halt, then everything after it is blocked
1 0 0000 0000 0000 0 0 0 0 0 0 1 1 0 3  0 0 0000 0 0000 0f0f 2222 000f 0
1 0 0555 0000 0000 2 0 0 0 1 0 1 0 1 2  0 0 0000 0 0000 0202 0303 000f 0
1 0 0000 0000 7777 0 0 0 0 0 1 1 0 2 1  0 0 0000 0 0000 0303 0202 000f 0
1 0 0666 0000 0000 1 0 0 0 1 0 1 0 2 2  0 0 0000 0 0000 0303 0303 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 0  0 0 0000 0 0000 0202 0f0f 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 3  0 0 0000 0 0000 0202 2222 0010 1
1 0 0aaa 0000 0000 0 0 0 0 1 0 1 0 0 2  0 0 0000 0 0000 0f0f 0303 0010 1
1 0 0000 0000 4321 0 0 0 0 0 1 1 0 3 1  0 0 0000 0 0000 2222 0202 0010 1
1 0 0000 0000 0000 0 0 0 0 0 0 1 1 1 1  0 0 0000 0 0000 0202 0202 0010 1
1 0 0040 9999 0000 0 0 1 0 0 0 1 0 2 0  0 0 0000 0 0000 0303 0f0f 0010 1
1 0 0040 0000 0000 3 1 0 1 1 0 1 0 3 3  0 0 0000 0 0000 2222 2222 0010 1
1 1 0bbb 0000 0000 1 0 0 0 1 0 1 0 0 1  0 0 0000 0 0000 0f0f 0202 0010 1
1 0 0ccc 0000 8888 2 0 0 0 1 1 1 0 2 3  0 0 0000 0 0000 0303 2222 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 0  0 0 0000 0 0000 0f0f 0f0f 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 1 2  0 0 0000 0 0000 0202 0303 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 3 0  0 0 0000 0 0000 2222 0f0f 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 2 1  0 0 0000 0 0000 0303 0202 0010 1
0 0 0000 0000 0000 0 0 0 0 0 0 0 0 0 3  0 0 0000 0 0000 0f0f 2222 0010 1

/* build.f */
src/back_end_pkg.sv
src/pipe_latch.sv
src/mem_stage.sv
src/reg_file.sv
src/wb_unit.sv
src/cpu_back_end.sv
bench/cpu_back_end_assert.sv
bench/cpu_back_end_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --assert --top-module cpu_back_end_tb --Mdir "$OBJ_DIR" -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vcpu_back_end_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* bench/cpu_back_end_tb.sv */
`timescale 1ns/100ps

module cpu_back_end_tb
    import back_end_pkg::*;
();

    localparam string DATA_FILE    = "bench/back_end_input.txt";
    localparam int    RESET_CYCLES = 8;
    localparam int    FIELDS       = 24;

    logic      clk;
    logic      reset_n;
    logic      flush;
    logic      ex_valid;
    word_t     ex_alu_result;
    word_t     ex_store_data;
    word_t     ex_r_data1;
    reg_addr_t ex_rd;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_mem_to_reg;
    logic      ex_reg_write;
    logic      ex_is_wwd;
    logic      ex_is_done;
    logic      ex_halt_op;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      wb_write;
    reg_addr_t wb_rd;
    word_t     wb_data;
    word_t     output_port;
    logic      output_valid;
    word_t     num_inst;
    logic      halted;

    // one entry per data line, comments stripped
    string lines[$];

    int   cycle_count;
    int   cycle_limit;
    logic running;

    cpu_back_end #(.MEM_DEPTH(MEM_DEPTH_DEFAULT)) dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush         (flush),
        .ex_valid      (ex_valid),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_r_data1    (ex_r_data1),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_reg_write  (ex_reg_write),
        .ex_is_wwd     (ex_is_wwd),
        .ex_is_done    (ex_is_done),
        .ex_halt_op    (ex_halt_op),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .wb_write      (wb_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .output_port   (output_port),
        .output_valid  (output_valid),
        .num_inst      (num_inst),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual,
                              input word_t expected, input int idx);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected 0x%h, got 0x%h (data line %0d)",
                                name, expected, actual, idx));
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t actual,
                                  input reg_addr_t expected, input int idx);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected 0x%h, got 0x%h (data line %0d)",
                                name, expected, actual, idx));
        end
    endtask

    task automatic check_bit(input string name, input logic actual,
                             input logic expected, input int idx);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected 0x%h, got 0x%h (data line %0d)",
                                name, expected, actual, idx));
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        string text;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file bench/back_end_input.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(text, fd) != 0) begin
                // skip comments and blank lines
                if (text.len() > 1 && text.getc(0) != "#") begin
                    lines.push_back(text);
                end
            end
        end
        $fclose(fd);
    endtask

    // drive one line after the edge, check its expected values at the falling edge
    task automatic run_line(input int idx);
        logic      v, f, mr, mw, mt, rw, ww, dn, ht;
        word_t     alu, sdat, r1;
        reg_addr_t rd, rs, rt;
        logic      exp_w, exp_o, exp_h;
        reg_addr_t exp_wr;
        word_t     exp_wbd, exp_op, exp_rsd, exp_rtd, exp_ni;
        int        n;
        n = $sscanf(lines[idx],
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            v, f, alu, sdat, r1, rd, mr, mw, mt, rw, ww, dn, ht, rs, rt,
            exp_w, exp_wr, exp_wbd, exp_o, exp_op, exp_rsd, exp_rtd, exp_ni, exp_h);
        if (n != FIELDS) begin
            abort_run($sformatf("data line %0d has %0d fields instead of %0d",
                                idx, n, FIELDS));
        end
        @(posedge clk);
        #2;
        ex_valid      = v;
        flush         = f;
        ex_alu_result = alu;
        ex_store_data = sdat;
        ex_r_data1    = r1;
        ex_rd         = rd;
        ex_mem_read   = mr;
        ex_mem_write  = mw;
        ex_mem_to_reg = mt;
        ex_reg_write  = rw;
        ex_is_wwd     = ww;
        ex_is_done    = dn;
        ex_halt_op    = ht;
        rs_addr       = rs;
        rt_addr       = rt;
        @(negedge clk);
        check_bit("wb_write", wb_write, exp_w, idx);
        // write address and data only mean something with a write
        if (exp_w) begin
            check_reg_addr("wb_rd", wb_rd, exp_wr, idx);
            check_word("wb_data", wb_data, exp_wbd, idx);
        end
        check_bit("output_valid", output_valid, exp_o, idx);
        if (exp_o) begin
            check_word("output_port", output_port, exp_op, idx);
        end
        check_word("rs_data", rs_data, exp_rsd, idx);
        check_word("rt_data", rt_data, exp_rtd, idx);
        check_word("num_inst", num_inst, exp_ni, idx);
        check_bit("halted", halted, exp_h, idx);
    endtask

    // run limit counted from the end of reset
    always @(posedge clk) begin
        if (running) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                abort_run($sformatf("timeout: stimulus still running after %0d cycles",
                                    cycle_limit));
            end
        end
    end

    initial begin
        reset_n       = 1'b1;
        flush         = 1'b0;
        ex_valid      = 1'b0;
        ex_alu_result = '0;
        ex_store_data = '0;
        ex_r_data1    = '0;
        ex_rd         = '0;
        ex_mem_read   = 1'b0;
        ex_mem_write  = 1'b0;
        ex_mem_to_reg = 1'b0;
        ex_reg_write  = 1'b0;
        ex_is_wwd     = 1'b0;
        ex_is_done    = 1'b0;
        ex_halt_op    = 1'b0;
        rs_addr       = '0;
        rt_addr       = '0;
        running       = 1'b0;
        cycle_count   = 0;
        cycle_limit   = 0;
        read_stimulus();
        if (lines.size() == 0) begin
            abort_run("the stimulus file holds no data lines");
        end
        cycle_limit = lines.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b0;
        running = 1'b1;
        for (int i = 0; i < lines.size(); i++) begin
            run_line(i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* bench/cpu_back_end_assert.sv */
`timescale 1ns/100ps

module cpu_back_end_assert
    import back_end_pkg::*;
(
    input logic  clk,
    input logic  reset_n,
    input logic  flush,
    input logic  ex_valid,
    input logic  wb_write,
    input logic  output_valid,
    input word_t num_inst,
    input logic  halted
);

    // a halted core neither writes nor strobes the output port
    halt_blocks_writeback: assert property (
        @(posedge clk) disable iff (reset_n)
        halted |-> !(wb_write || output_valid)
    ) else $error("register write or output strobe while halted");

    // flushed instruction arrives at writeback two cycles later as a bubble
    flush_makes_bubble: assert property (
        @(posedge clk) disable iff (reset_n)
        ($past(flush, 2) && $past(ex_valid, 2)) |-> !(wb_write || output_valid)
    ) else $error("flushed instruction reached writeback");

    count_never_drops: assert property (
        @(posedge clk) disable iff (reset_n)
        num_inst >= $past(num_inst)
    ) else $error("retired instruction count went down");

endmodule

bind cpu_back_end cpu_back_end_assert assert_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .flush        (flush),
    .ex_valid     (ex_valid),
    .wb_write     (wb_write),
    .output_valid (output_valid),
    .num_inst     (num_inst),
    .halted       (halted)
);

/* src/cpu_back_end.sv */
`timescale 1ns/100ps

module cpu_back_end
    import back_end_pkg::*;
#(
    parameter int MEM_DEPTH = MEM_DEPTH_DEFAULT
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      flush,
    input  logic      ex_valid,
    input  word_t     ex_alu_result,
    input  word_t     ex_store_data,
    input  word_t     ex_r_data1,
    input  reg_addr_t ex_rd,
    input  logic      ex_mem_read,
    input  logic      ex_mem_write,
    input  logic      ex_mem_to_reg,
    input  logic      ex_reg_write,
    input  logic      ex_is_wwd,
    input  logic      ex_is_done,
    input  logic      ex_halt_op,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    output logic      wb_write,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output word_t     output_port,
    output logic      output_valid,
    output word_t     num_inst,
    output logic      halted
);

    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    ex_mem_valid;

    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    logic    mem_wb_valid;

    word_t   mem_data;

    // execute fields into the EX/MEM payload
    assign ex_mem_d = '{
        alu_result: ex_alu_result,
        store_data: ex_store_data,
        r_data1:    ex_r_data1,
        rd:         ex_rd,
        mem_read:   ex_mem_read,
        mem_write:  ex_mem_write,
        mem_to_reg: ex_mem_to_reg,
        reg_write:  ex_reg_write,
        is_wwd:     ex_is_wwd,
        is_done:    ex_is_done,
        halt_op:    ex_halt_op
    };

    // flush only ever kills the instruction entering EX/MEM
    pipe_latch #(.payload_t(ex_mem_t)) ex_mem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (flush),
        .in_valid  (ex_valid),
        .in_data   (ex_mem_d),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem_q)
    );

    mem_stage #(.MEM_DEPTH(MEM_DEPTH)) mem_stage_i (
        .clk        (clk),
        .valid      (ex_mem_valid),
        .mem_read   (ex_mem_q.mem_read),
        .mem_write  (ex_mem_q.mem_write),
        .addr       (ex_mem_q.alu_result),
        .store_data (ex_mem_q.store_data),
        .mem_data   (mem_data)
    );

    // load data joins the rest of the latched fields
    assign mem_wb_d = '{
        mem_data:   mem_data,
        alu_result: ex_mem_q.alu_result,
        r_data1:    ex_mem_q.r_data1,
        rd:         ex_mem_q.rd,
        mem_to_reg: ex_mem_q.mem_to_reg,
        reg_write:  ex_mem_q.reg_write,
        is_wwd:     ex_mem_q.is_wwd,
        is_done:    ex_mem_q.is_done,
        halt_op:    ex_mem_q.halt_op
    };

    pipe_latch #(.payload_t(mem_wb_t)) mem_wb_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (1'b0),
        .in_valid  (ex_mem_valid),
        .in_data   (mem_wb_d),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb_q)
    );

    wb_unit wb_unit_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .valid        (mem_wb_valid),
        .mem_to_reg   (mem_wb_q.mem_to_reg),
        .reg_write    (mem_wb_q.reg_write),
        .is_wwd       (mem_wb_q.is_wwd),
        .is_done      (mem_wb_q.is_done),
        .halt_op      (mem_wb_q.halt_op),
        .mem_data     (mem_wb_q.mem_data),
        .alu_result   (mem_wb_q.alu_result),
        .r_data1      (mem_wb_q.r_data1),
        .rd           (mem_wb_q.rd),
        .wb_write     (wb_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .halted       (halted)
    );

    // write port comes straight from writeback
    reg_file reg_file_i (
        .clk     (clk),
        .reset_n (reset_n),
        .write   (wb_write),
        .wr_addr (wb_rd),
        .wr_data (wb_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

/* src/wb_unit.sv */
`timescale 1ns/100ps

module wb_unit
    import back_end_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      valid,
    input  logic      mem_to_reg,
    input  logic      reg_write,
    input  logic      is_wwd,
    input  logic      is_done,
    input  logic      halt_op,
    input  word_t     mem_data,
    input  word_t     alu_result,
    input  word_t     r_data1,
    input  reg_addr_t rd,
    output logic      wb_write,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output word_t     output_port,
    output logic      output_valid,
    output word_t     num_inst,
    output logic      halted
);

    // an instruction retires only while the core is still running
    logic retire;

    assign retire = valid & ~halted;

    // loaded word or alu result
    assign wb_data = mem_to_reg ? mem_data : alu_result;
    assign wb_rd   = rd;

    assign wb_write = retire & reg_write;

    // wwd puts the first source operand on the output port
    assign output_valid = retire & is_wwd;
    assign output_port  = r_data1;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
            halted   <= 1'b0;
        end else begin
            if (retire && is_done) begin
                num_inst <= num_inst + word_t'(1);
            end
            // sticky until the next reset
            if (retire && halt_op) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file
    import back_end_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      write,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [4];

    logic rs_bypass;
    logic rt_bypass;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so a read in the writeback cycle sees the new value
    assign rs_bypass = write && (wr_addr == rs_addr);
    assign rt_bypass = write && (wr_addr == rt_addr);

    assign rs_data = rs_bypass ? wr_data : regs[rs_addr];
    assign rt_data = rt_bypass ? wr_data : regs[rt_addr];

endmodule

/* src/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage
    import back_end_pkg::*;
#(
    parameter int MEM_DEPTH = MEM_DEPTH_DEFAULT
) (
    input  logic  clk,
    input  logic  valid,
    input  logic  mem_read,
    input  logic  mem_write,
    input  word_t addr,
    input  word_t store_data,
    output word_t mem_data
);

    localparam int ADDR_BITS = $clog2(MEM_DEPTH);

    // word addressed data memory
    word_t mem [MEM_DEPTH];

    logic [ADDR_BITS-1:0] index;
    logic                 do_load;
    logic                 do_store;

    // only the low address bits select a word
    assign index = addr[ADDR_BITS-1:0];

    // bubbles never touch memory
    assign do_load  = valid & mem_read;
    assign do_store = valid & mem_write;

    always_ff @(posedge clk) begin
        if (do_store) begin
            mem[index] <= store_data;
        end
    end

    // load data is combinational within the MEM cycle
    // zero when nothing is loaded
    assign mem_data = do_load ? mem[index] : '0;

endmodule

/* src/pipe_latch.sv */
`timescale 1ns/100ps

module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit marks a real instruction, a low bit is a bubble
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid & ~flush;
        end
    end

    // payload loads every cycle, control fields stay as they came in
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

/* src/back_end_pkg.sv */
package back_end_pkg;

    // data path width and default memory size
    localparam int WORD_SIZE         = 16;
    localparam int MEM_DEPTH_DEFAULT = 256;

    typedef logic [WORD_SIZE-1:0] word_t;

    // four general registers
    typedef logic [1:0] reg_addr_t;

    // fields carried from execute into the memory stage
    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        word_t     r_data1;
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      reg_write;
        logic      is_wwd;
        logic      is_done;
        logic      halt_op;
    } ex_mem_t;

    // fields carried from the memory stage into writeback
    typedef struct packed {
        word_t     mem_data;
        word_t     alu_result;
        word_t     r_data1;
        reg_addr_t rd;
        logic      mem_to_reg;
        logic      reg_write;
        logic      is_wwd;
        logic      is_done;
        logic      halt_op;
    } mem_wb_t;

endpackage
